/* common/lpc_consts.svh */
// latencies, sizes and register map of the alpha block; include where a module needs them.
`ifndef LPC_CONSTS_SVH
`define LPC_CONSTS_SVH

`define LPC_MULT_LATENCY 5
`define LPC_ADD_LATENCY 7
`define LPC_MAX_PAIRS 8
`define LPC_MAX_COEFS 16

// ##################################################
// register map, byte addresses on a 10-bit bus.
`define LPC_REG_CTRL 10'h000
`define LPC_REG_STATUS 10'h004
`define LPC_REG_ALPHA 10'h008
`define LPC_ACF_BASE 10'h040
`define LPC_MODEL_BASE 10'h080
`define LPC_BANK_MASK 10'h3c0

`endif

/* common/lpc_pkg.sv */
// shared types of the alpha block; modules import what they use.
package lpc_pkg;

    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // one float word, seen as bus data or as its fields.
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t f;
    } fp32_u;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [9:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        fp32_u acf1;
        fp32_u acf2;
        fp32_u model1;
        fp32_u model2;
        logic  valid;
    } term_pair_t;

endpackage

/* alpha/fp_mult.sv */
// five-stage single-precision multiplier, normal numbers and zero only, truncating.
`timescale 1ns/1ps

module fp_mult (
    input  logic           iClock,
    input  logic           rst_n,
    input  logic           clk_en,
    input  lpc_pkg::fp32_u dataa,
    input  lpc_pkg::fp32_u datab,
    output lpc_pkg::fp32_u result
);
    import lpc_pkg::*;

    fp32_fields_t      a1;
    fp32_fields_t      b1;
    logic              zero1, zero2, zero3, zero4;
    logic              sign2, sign3, sign4;
    logic [9:0]        exp2;
    logic signed [9:0] exp3;
    logic signed [9:0] exp4;
    logic [47:0]       prod2;
    logic [47:0]       prod3;
    logic [22:0]       man4;

    always_ff @(posedge iClock) begin
        if (clk_en) begin
            a1    <= dataa.f;
            b1    <= datab.f;
            zero1 <= (dataa.f.exponent == 8'd0) || (datab.f.exponent == 8'd0);

            sign2 <= a1.sign ^ b1.sign;
            exp2  <= {2'b00, a1.exponent} + {2'b00, b1.exponent};
            prod2 <= {24'd0, 1'b1, a1.mantissa} * {24'd0, 1'b1, b1.mantissa};
            zero2 <= zero1;

            sign3 <= sign2;
            exp3  <= $signed(exp2) - 10'sd127; // drop one bias.
            prod3 <= prod2;
            zero3 <= zero2;

            // product of two 1.x values lies in [1, 4).
            if (prod3[47]) begin
                man4 <= prod3[46:24];
                exp4 <= exp3 + 10'sd1;
            end else begin
                man4 <= prod3[45:23];
                exp4 <= exp3;
            end
            sign4 <= sign3;
            zero4 <= zero3;
        end
    end

    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            result <= '0;
        end else if (clk_en) begin
            if (zero4 || exp4 <= 10'sd0) begin
                result.raw <= 32'd0; // underflow flushes.
            end else if (exp4 >= 10'sd255) begin
                result.raw <= {sign4, 8'hfe, 23'h7fffff};
            end else begin
                result.raw <= {sign4, exp4[7:0], man4};
            end
        end
    end

endmodule

/* alpha/fp_add.sv */
// seven-stage single-precision adder, normal numbers and zero only, truncating.
`timescale 1ns/1ps

module fp_add (
    input  logic           iClock,
    input  logic           rst_n,
    input  logic           clk_en,
    input  lpc_pkg::fp32_u dataa,
    input  lpc_pkg::fp32_u datab,
    output lpc_pkg::fp32_u result
);
    import lpc_pkg::*;

    fp32_fields_t      a1, b1;
    fp32_fields_t      big, little;
    logic              swap;
    logic              sign_b2, sign_s2;
    logic [7:0]        exp2, diff2;
    logic [23:0]       man_b2, man_s2;
    logic              sign3, sub3;
    logic [7:0]        exp3;
    logic [23:0]       man_b3, man_s3;
    logic              sign4;
    logic [7:0]        exp4;
    logic [24:0]       sum4;
    logic              sign5;
    logic [7:0]        exp5;
    logic [24:0]       sum5;
    logic [4:0]        lz5;
    logic              sign6, zero6;
    logic signed [9:0] exp6;
    logic [24:0]       norm6;

    function automatic logic [4:0] clz25(input logic [24:0] v);
        logic [4:0] n;
        logic       hit;
        n   = 5'd25;
        hit = 1'b0;
        for (int i = 24; i >= 0; i--) begin
            if (!hit && v[i]) begin
                n   = 5'(24 - i);
                hit = 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        swap   = {b1.exponent, b1.mantissa} > {a1.exponent, a1.mantissa};
        big    = swap ? b1 : a1;
        little = swap ? a1 : b1;
    end

    // ##################################################
    // pipeline.
    always_ff @(posedge iClock) begin
        if (clk_en) begin
            a1 <= dataa.f;
            b1 <= datab.f;

            // larger magnitude goes first.
            sign_b2 <= big.sign;
            sign_s2 <= little.sign;
            exp2    <= big.exponent;
            diff2   <= big.exponent - little.exponent;
            man_b2  <= {big.exponent != 8'd0, big.mantissa};
            man_s2  <= {little.exponent != 8'd0, little.mantissa};

            sign3  <= sign_b2;
            sub3   <= sign_b2 ^ sign_s2;
            exp3   <= exp2;
            man_b3 <= man_b2;
            man_s3 <= man_s2 >> diff2; // bits shifted out are lost.

            sign4 <= sign3;
            exp4  <= exp3;
            if (sub3) begin
                sum4 <= {1'b0, man_b3} - {1'b0, man_s3};
            end else begin
                sum4 <= {1'b0, man_b3} + {1'b0, man_s3};
            end

            sign5 <= sign4;
            exp5  <= exp4;
            sum5  <= sum4;
            lz5   <= clz25(sum4);

            sign6 <= sign5;
            zero6 <= (sum5 == 25'd0);
            norm6 <= sum5 << lz5;
            exp6  <= $signed({2'b00, exp5}) + 10'sd1 - $signed({5'b00000, lz5});
        end
    end

    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            result <= '0;
        end else if (clk_en) begin
            if (zero6 || exp6 <= 10'sd0) begin
                result.raw <= 32'd0; // exact cancellation is +0.
            end else if (exp6 >= 10'sd255) begin
                result.raw <= {sign6, 8'hfe, 23'h7fffff};
            end else begin
                result.raw <= {sign6, exp6[7:0], norm6[23:1]};
            end
        end
    end

endmodule

/* alpha/alpha_calc.sv */
// alpha calculator: pair products, first-level sums, then a three-pass reduction to alpha.
`timescale 1ns/1ps
`include "lpc_consts.svh"

module alpha_calc (
    input  logic                iClock,
    input  logic                rst_n,
    input  lpc_pkg::term_pair_t pair,
    input  logic                start,
    output lpc_pkg::fp32_u      result,
    output logic                done
);
    import lpc_pkg::*;

    localparam int FIRST_LAT  = `LPC_MULT_LATENCY + `LPC_ADD_LATENCY;
    localparam int ADD_LAT    = `LPC_ADD_LATENCY;
    localparam int BANK_DEPTH = `LPC_MAX_PAIRS / 2;

    typedef enum logic [2:0] {S_IDLE, S_PASS1, S_PASS2, S_PASS3, S_DONE} state_t;

    state_t               state;
    term_pair_t           r_pair;
    fp32_u                m_lo_out, m_hi_out, first_sum, tree_sum;
    fp32_u                tree_a, tree_b;
    logic [FIRST_LAT-1:0] first_sr;
    logic [ADD_LAT-1:0]   tree_sr;
    fp32_u                bank_a [BANK_DEPTH];
    fp32_u                bank_b [BANK_DEPTH];
    fp32_u                bank_c [2];
    fp32_u                bank_d [2];
    fp32_u                word_e, word_f;
    logic [3:0]           sum_cnt;
    logic [2:0]           iss, ret, lim;
    logic                 issue;

    // the stream never stalls, so the units run every cycle.
    fp_mult m_lo (
        .iClock(iClock),
        .rst_n (rst_n),
        .clk_en(1'b1),
        .dataa (r_pair.acf2),
        .datab (r_pair.model1),
        .result(m_lo_out)
    );

    fp_mult m_hi (
        .iClock(iClock),
        .rst_n (rst_n),
        .clk_en(1'b1),
        .dataa (r_pair.acf1),
        .datab (r_pair.model2),
        .result(m_hi_out)
    );

    fp_add a_first (
        .iClock(iClock),
        .rst_n (rst_n),
        .clk_en(1'b1),
        .dataa (m_lo_out),
        .datab (m_hi_out),
        .result(first_sum)
    );

    fp_add a_tree (
        .iClock(iClock),
        .rst_n (rst_n),
        .clk_en(1'b1),
        .dataa (tree_a),
        .datab (tree_b),
        .result(tree_sum)
    );

    // ##################################################
    // number of adds each pass issues.
    always_comb begin
        case (state)
            S_PASS1: lim = 3'((sum_cnt + 4'd1) >> 1);
            S_PASS2: lim = 3'((sum_cnt + 4'd3) >> 2);
            S_PASS3: lim = 3'd1;
            default: lim = 3'd0;
        endcase
    end

    assign issue = (iss < lim);

    always_comb begin
        tree_a = '0;
        tree_b = '0;
        if (issue) begin
            case (state)
                S_PASS1: begin
                    tree_a = bank_a[iss[1:0]];
                    tree_b = bank_b[iss[1:0]];
                end
                S_PASS2: begin
                    tree_a = bank_c[iss[0]];
                    tree_b = bank_d[iss[0]];
                end
                S_PASS3: begin
                    tree_a = word_e;
                    tree_b = word_f;
                end
                default: ;
            endcase
        end
    end

    // ##################################################
    // control.
    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            r_pair   <= '0;
            first_sr <= '0;
            tree_sr  <= '0;
            sum_cnt  <= '0;
            iss      <= '0;
            ret      <= '0;
            done     <= 1'b0;
        end else begin
            r_pair   <= pair;
            first_sr <= {first_sr[FIRST_LAT-2:0], r_pair.valid};
            tree_sr  <= {tree_sr[ADD_LAT-2:0], issue};
            if (issue) begin
                iss <= iss + 3'd1;
            end
            if (start) begin
                state   <= S_IDLE;
                tree_sr <= '0;
                sum_cnt <= '0;
                iss     <= '0;
                ret     <= '0;
                done    <= 1'b0;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (first_sr[FIRST_LAT-1]) begin
                            sum_cnt <= sum_cnt + 4'd1;
                        end
                        if (first_sr[FIRST_LAT-1] && !first_sr[FIRST_LAT-2]) begin
                            state <= S_PASS1; // last first-level sum is in.
                        end
                    end
                    S_PASS1, S_PASS2: begin
                        if (tree_sr[ADD_LAT-1]) begin
                            ret <= ret + 3'd1;
                        end
                        if (tree_sr[ADD_LAT-1] && !tree_sr[ADD_LAT-2]) begin
                            state <= (state == S_PASS1) ? S_PASS2 : S_PASS3;
                            iss   <= '0;
                            ret   <= '0;
                        end
                    end
                    S_PASS3: begin
                        if (tree_sr[ADD_LAT-1]) begin
                            done  <= 1'b1;
                            state <= S_DONE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // partial sum storage; empty slots stay zero for short runs.
    always_ff @(posedge iClock) begin
        if (start) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                bank_a[i] <= '0;
                bank_b[i] <= '0;
            end
            for (int i = 0; i < 2; i++) begin
                bank_c[i] <= '0;
                bank_d[i] <= '0;
            end
            word_e <= '0;
            word_f <= '0;
        end else begin
            if (state == S_IDLE && first_sr[FIRST_LAT-1]) begin
                if (sum_cnt[0]) begin
                    bank_b[sum_cnt[2:1]] <= first_sum;
                end else begin
                    bank_a[sum_cnt[2:1]] <= first_sum;
                end
            end
            if (tree_sr[ADD_LAT-1]) begin
                case (state)
                    S_PASS1: begin
                        if (ret[0]) begin
                            bank_d[ret[1]] <= tree_sum;
                        end else begin
                            bank_c[ret[1]] <= tree_sum;
                        end
                    end
                    S_PASS2: begin
                        if (ret[0]) begin
                            word_f <= tree_sum;
                        end else begin
                            word_e <= tree_sum;
                        end
                    end
                    S_PASS3: result <= tree_sum;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verilog/coef_regs.sv */
// Wishbone classic register block: coefficient banks, control, status, alpha and pair sequencer.
`timescale 1ns/1ps
`include "lpc_consts.svh"

module coef_regs (
    input  logic                iClock,
    input  logic                rst_n,
    input  lpc_pkg::wb_req_t    wb_req,
    output lpc_pkg::wb_rsp_t    wb_rsp,
    output lpc_pkg::term_pair_t pair,
    output logic                start,
    input  lpc_pkg::fp32_u      result,
    input  logic                done
);
    logic [31:0] acf   [`LPC_MAX_COEFS];
    logic [31:0] model [`LPC_MAX_COEFS];
    logic [31:0] alpha_q, rd_data, rd_mux;
    logic        ack, busy, done_flag, done_d, streaming;
    logic [3:0]  count, req_cnt, word_idx;
    logic [2:0]  idx;
    logic        access, wr, is_acf, is_model, start_req;

    function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                          input logic [3:0] sel);
        logic [31:0] m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return m;
    endfunction

    assign access    = wb_req.cyc && wb_req.stb && !ack; // ack one clock after the request.
    assign wr        = access && wb_req.we;
    assign word_idx  = wb_req.adr[5:2];
    assign req_cnt   = wb_req.dat[7:4];
    assign is_acf    = (wb_req.adr & `LPC_BANK_MASK) == `LPC_ACF_BASE;
    assign is_model  = (wb_req.adr & `LPC_BANK_MASK) == `LPC_MODEL_BASE;
    assign start_req = wr && (wb_req.adr == `LPC_REG_CTRL) && wb_req.dat[0] && !busy;
    assign wb_rsp    = '{ack: ack, dat: rd_data};

    always_comb begin
        if (is_acf) begin
            rd_mux = acf[word_idx];
        end else if (is_model) begin
            rd_mux = model[word_idx];
        end else begin
            case (wb_req.adr)
                `LPC_REG_CTRL:   rd_mux = {24'd0, count, 4'd0};
                `LPC_REG_STATUS: rd_mux = {30'd0, busy, done_flag};
                `LPC_REG_ALPHA:  rd_mux = alpha_q;
                default:         rd_mux = 32'd0;
            endcase
        end
    end

    // pair t is words 2t and 2t+1 of each bank.
    always_comb begin
        pair.acf2.raw   = acf[{idx, 1'b0}];
        pair.model1.raw = model[{idx, 1'b0}];
        pair.acf1.raw   = acf[{idx, 1'b1}];
        pair.model2.raw = model[{idx, 1'b1}];
        pair.valid      = streaming;
    end

    // ##################################################
    // bus side.
    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            ack <= 1'b0;
            for (int i = 0; i < `LPC_MAX_COEFS; i++) begin
                acf[i]   <= 32'd0;
                model[i] <= 32'd0;
            end
        end else begin
            ack <= access;
            if (wr && is_acf) begin
                acf[word_idx] <= merge(acf[word_idx], wb_req.dat, wb_req.sel);
            end
            if (wr && is_model) begin
                model[word_idx] <= merge(model[word_idx], wb_req.dat, wb_req.sel);
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (access && !wb_req.we) begin
            rd_data <= rd_mux;
        end
    end

    // ##################################################
    // run control and sequencer.
    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            start     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            done_d    <= 1'b0;
            streaming <= 1'b0;
            count     <= 4'd0;
            idx       <= 3'd0;
            alpha_q   <= 32'd0;
        end else begin
            start  <= start_req;
            done_d <= done;
            if (start_req) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
                if (req_cnt == 4'd0) begin
                    count <= 4'd1;
                end else if (req_cnt > 4'(`LPC_MAX_PAIRS)) begin
                    count <= 4'(`LPC_MAX_PAIRS);
                end else begin
                    count <= req_cnt;
                end
            end
            // pairs follow the start write ack.
            if (start) begin
                streaming <= 1'b1;
                idx       <= 3'd0;
            end else if (streaming) begin
                if (idx == 3'(count - 4'd1)) begin
                    streaming <= 1'b0;
                end else begin
                    idx <= idx + 3'd1;
                end
            end
            if (busy && done && !done_d) begin
                alpha_q   <= result.raw;
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
        end
    end

endmodule

/* verilog/lpc_alpha_top.sv */
// top level of the alpha subsystem; the Wishbone register block feeds the alpha calculator.
`timescale 1ns/1ps

module lpc_alpha_top (
    input  logic             iClock,
    input  logic             rst_n,
    input  lpc_pkg::wb_req_t wb_req,
    output lpc_pkg::wb_rsp_t wb_rsp
);
    import lpc_pkg::*;

    term_pair_t pair;
    fp32_u      result;
    logic       start;
    logic       done;

    coef_regs u_regs (
        .iClock(iClock),
        .rst_n (rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .pair  (pair),
        .start (start),
        .result(result),
        .done  (done)
    );

    alpha_calc u_alpha (
        .iClock(iClock),
        .rst_n (rst_n),
        .pair  (pair),
        .start (start),
        .result(result),
        .done  (done)
    );

endmodule

/* bench/tb_lpc_alpha.sv */
// testbench for the alpha subsystem; drives Wishbone cycles and checks alpha against integer dot products.
`timescale 1ns/1ps
`include "lpc_consts.svh"

module tb_lpc_alpha;
    import lpc_pkg::*;

    localparam int CYCLE_LIMIT = 4000; // six runs of up to 200 cycles, plus bus traffic and margin.

    logic    iClock;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int acf_val   [`LPC_MAX_COEFS]; // integer values behind the float words in the DUT.
    int model_val [`LPC_MAX_COEFS];

    lpc_alpha_top i_dut (
        .iClock(iClock),
        .rst_n (rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    always #5 iClock = ~iClock;

    always @(posedge iClock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ##################################################
    // reference arithmetic.
    function automatic logic [31:0] float_bits(input int value);
        logic        sign;
        int          mag;
        int          msb;
        logic [31:0] frac;
        if (value == 0) begin
            return 32'd0;
        end
        sign = value < 0;
        mag  = sign ? -value : value;
        msb  = 0;
        for (int i = 0; i < 31; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        frac = 32'(mag) << (23 - msb); // hidden bit lands on bit 23.
        return {sign, 8'(127 + msb), frac[22:0]};
    endfunction

    function automatic logic [31:0] expected_alpha(input int pairs);
        int sum;
        sum = 0;
        for (int k = 0; k < 2 * pairs; k++) begin
            sum += acf_val[k] * model_val[k];
        end
        return float_bits(sum);
    endfunction

    function automatic int small_rand();
        return int'($urandom % 17) - 8;
    endfunction

    function automatic int nonzero_rand();
        int v;
        v = small_rand();
        while (v == 0) begin
            v = small_rand();
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // ##################################################
    // Wishbone classic master.
    task automatic bus_cycle(input logic we, input logic [9:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int waits;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = 4'hf;
        waits      = 0;
        do begin
            @(posedge iClock);
            #1;
            waits++;
        end while (!wb_rsp.ack && waits < 8);
        assert (wb_rsp.ack) else begin
            $display("bus cycle at address %h got no ack within 8 clocks", adr);
            errors++;
        end
        check_value("wb ack on second clock", 32'd1, 32'(waits));
        rdata      = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(posedge iClock);
        #1;
        assert (!wb_rsp.ack) else begin
            $display("ack at address %h stayed high for more than one clock", adr);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [9:0] adr, input logic [31:0] dat);
        logic [31:0] unused_data;
        bus_cycle(1'b1, adr, dat, unused_data);
    endtask

    task automatic wb_read(input logic [9:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'd0, dat);
    endtask

    // ##################################################
    // run helpers.
    task automatic load_coef(input int idx, input int a, input int m);
        acf_val[idx]   = a;
        model_val[idx] = m;
        wb_write(`LPC_ACF_BASE + 10'(4 * idx), float_bits(a));
        wb_write(`LPC_MODEL_BASE + 10'(4 * idx), float_bits(m));
    endtask

    task automatic load_banks(input logic nonzero);
        for (int k = 0; k < `LPC_MAX_COEFS; k++) begin
            if (nonzero) begin
                load_coef(k, nonzero_rand(), nonzero_rand());
            end else begin
                load_coef(k, small_rand(), small_rand());
            end
        end
    endtask

    task automatic start_run(input int pairs);
        wb_write(`LPC_REG_CTRL, {24'd0, 4'(pairs), 4'b0001});
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = 32'd0;
        while (!status[0]) begin
            wb_read(`LPC_REG_STATUS, status); // the cycle counter bounds this loop.
        end
    endtask

    task automatic run_and_check(input string name, input int pairs, output logic [31:0] alpha);
        start_run(pairs);
        wait_done();
        wb_read(`LPC_REG_ALPHA, alpha);
        check_value(name, expected_alpha(pairs), alpha);
    endtask

    // ##################################################
    // stimulus.
    initial begin
        logic [31:0] rd;
        logic [31:0] word;
        int          idx;
        iClock = 1'b0;
        rst_n  = 1'b0;
        wb_req = '0;
        void'($urandom(50));
        repeat (10) @(posedge iClock);
        #1;
        rst_n = 1'b1;
        @(posedge iClock);
        #1;

        wb_read(`LPC_REG_STATUS, rd);
        check_value("reset status", 32'd0, rd);
        wb_read(`LPC_REG_ALPHA, rd);
        check_value("reset alpha", 32'd0, rd);
        wb_read(`LPC_ACF_BASE + 10'd12, rd);
        check_value("reset acf bank", 32'd0, rd);

        // register readback.
        for (int n = 0; n < 4; n++) begin
            idx  = int'($urandom % 16);
            word = $urandom;
            wb_write(`LPC_ACF_BASE + 10'(4 * idx), word);
            wb_read(`LPC_ACF_BASE + 10'(4 * idx), rd);
            check_value("acf readback", word, rd);
            word = $urandom;
            wb_write(`LPC_MODEL_BASE + 10'(4 * idx), word);
            wb_read(`LPC_MODEL_BASE + 10'(4 * idx), rd);
            check_value("model readback", word, rd);
        end

        load_banks(1'b0);
        run_and_check("full run", 8, rd);

        load_banks(1'b1); // upper indices must not leak into a short run.
        run_and_check("three pairs", 3, rd);

        load_coef(0, 3, 2);
        load_coef(1, -3, 2);
        run_and_check("exact cancel", 1, rd);
        check_value("exact cancel is +0", 32'h0000_0000, rd);
        load_coef(0, 5, -3);
        load_coef(1, 0, 7);
        run_and_check("negative term", 1, rd);
        check_value("negative term bits", 32'hc170_0000, rd); // -15.0.

        load_banks(1'b1);
        start_run(8);
        start_run(2); // busy, so this one is dropped.
        wait_done();
        wb_read(`LPC_REG_ALPHA, rd);
        check_value("start while busy", expected_alpha(8), rd);
        wb_read(`LPC_REG_CTRL, rd);
        check_value("count kept while busy", 32'h0000_0080, rd);

        load_banks(1'b0);
        start_run(4);
        wb_read(`LPC_REG_STATUS, rd);
        check_value("done cleared by restart", 32'h0000_0002, rd);
        wait_done();
        wb_read(`LPC_REG_ALPHA, rd);
        check_value("restart", expected_alpha(4), rd);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/lpc_pkg.sv
alpha/fp_mult.sv
alpha/fp_add.sv
alpha/alpha_calc.sv
verilog/coef_regs.sv
verilog/lpc_alpha_top.sv
bench/tb_lpc_alpha.sv

/* run.sh */
#!/bin/sh
# builds the alpha subsystem testbench with Verilator and runs it.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_lpc_alpha -f project.f -o tb_lpc_alpha &&
./obj_dir/tb_lpc_alpha | tee /dev/stderr | grep -qx "Testbench passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
